// ==== design/lane_pkg.sv ====
`default_nettype none

`include "lane_settings.svh"

package lane_pkg;

   typedef logic [$clog2(`LANE_DEPTH)-1:0] vaddr_t;
   typedef logic [`LANE_WORD-1:0] word_t;
   typedef logic [$clog2(`LANE_R_PORTS)-1:0] rport_t;
   typedef logic [1:0] bsel_t;

   // Code 3 is not named and reads as a full word
   typedef enum logic [1:0] {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } sew_t;

   // One VRF word seen as bytes or as halfwords
   typedef union packed {
      logic [`LANE_WORD/8-1:0][7:0]   bytes;
      logic [`LANE_WORD/16-1:0][15:0] halves;
   } word_view_u;

   ////////////////////////////////////////////////////////////////////////////
   // Write side

   typedef struct packed {
      vaddr_t                  addr;
      logic                    src;      // 0 ALU result, 1 load word
      word_t                   alu_data;
      logic [`LANE_WORD/8-1:0] be;
      logic                    mask_en;
      logic                    mask;
      logic                    valid;
   } wr_req_t;

   typedef struct packed {
      vaddr_t                  addr;
      word_t                   data;
      logic [`LANE_WORD/8-1:0] be;
   } vrf_wr_t;

   ////////////////////////////////////////////////////////////////////////////
   // Read side

   typedef struct packed {
      vaddr_t vs1_addr;
      bsel_t  vs1_bsel;
      vaddr_t vs2_addr;
      bsel_t  vs2_bsel;
      sew_t   sew;
      logic   valid;
   } op_req_t;

   typedef struct packed {
      rport_t port;
      logic   valid;
   } st_req_t;

   typedef struct packed {
      word_t vs1;
      word_t vs2;
      logic  valid;
   } op_rsp_t;

endpackage

`default_nettype wire

// ==== design/lane_read_path.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lane_settings.svh"

module lane_read_path (
   input  wire logic                                  clk_i,
   input  wire logic                                  rstn_i,
   input  wire lane_pkg::op_req_t [`LANE_W_PORTS-1:0] op_req_i,
   input  wire lane_pkg::st_req_t                     st_req_i,
   input  wire lane_pkg::word_t   [`LANE_R_PORTS-1:0] rdata_i,
   output lane_pkg::vaddr_t       [`LANE_R_PORTS-1:0] raddr_o,
   output lane_pkg::op_rsp_t      [`LANE_W_PORTS-1:0] op_rsp_o,
   output lane_pkg::word_t                            store_data_o,
   output logic                                       store_valid_o
);

   import lane_pkg::*;

   // Control must be held one stage longer than the RAM latency
   localparam int unsigned CTL_STAGES = `LANE_RAM_LAT + 1;
   localparam int unsigned LAST       = CTL_STAGES - 1;

   typedef struct packed {
      bsel_t [`LANE_R_PORTS-1:0] bsel;
      sew_t  [`LANE_W_PORTS-1:0] sew;
      rport_t                    st_port;
   } rd_ctl_t;

   typedef struct packed {
      logic [`LANE_W_PORTS-1:0] op;
      logic                     st;
   } rd_vld_t;

   rd_ctl_t                   ctl_d;
   rd_ctl_t [CTL_STAGES-1:0]  ctl_q;
   rd_vld_t                   vld_d;
   rd_vld_t [CTL_STAGES-1:0]  vld_q;
   rd_vld_t                   out_vld_q;
   word_t   [`LANE_R_PORTS-1:0] ext_d;
   word_t   [`LANE_R_PORTS-1:0] ext_q;
   rport_t                    st_port_q;

   // Byte or halfword pick, zero extended
   function automatic word_t trim(word_t raw, sew_t sew, bsel_t bsel);
      word_view_u view;
      view = raw;
      case (sew)
         SEW_8:   trim = word_t'(view.bytes[bsel]);
         SEW_16:  trim = word_t'(view.halves[bsel[1]]);
         default: trim = view;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Request side, slot k owns ports 2k and 2k+1

   always_comb begin
      for (int k = 0; k < `LANE_W_PORTS; k++) begin
         raddr_o[2*k]       = op_req_i[k].vs1_addr;
         raddr_o[2*k+1]     = op_req_i[k].vs2_addr;
         ctl_d.bsel[2*k]    = op_req_i[k].vs1_bsel;
         ctl_d.bsel[2*k+1]  = op_req_i[k].vs2_bsel;
         ctl_d.sew[k]       = op_req_i[k].sew;
         vld_d.op[k]        = op_req_i[k].valid;
      end
      ctl_d.st_port = st_req_i.port;
      vld_d.st      = st_req_i.valid;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Alignment with RAM data and extraction register

   always_comb begin
      for (int p = 0; p < `LANE_R_PORTS; p++) begin
         ext_d[p] = trim(rdata_i[p], ctl_q[LAST].sew[p/2], ctl_q[LAST].bsel[p]);
      end
   end

   always_ff @(posedge clk_i) begin
      ctl_q[0] <= ctl_d;
      for (int s = 1; s < CTL_STAGES; s++) begin
         ctl_q[s] <= ctl_q[s-1];
      end
      ext_q     <= ext_d;
      st_port_q <= ctl_q[LAST].st_port;
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         vld_q     <= '0;
         out_vld_q <= '0;
      end else begin
         vld_q[0] <= vld_d;
         for (int s = 1; s < CTL_STAGES; s++) begin
            vld_q[s] <= vld_q[s-1];
         end
         out_vld_q <= vld_q[LAST];
      end
   end

   always_comb begin
      for (int k = 0; k < `LANE_W_PORTS; k++) begin
         op_rsp_o[k].vs1   = ext_q[2*k];
         op_rsp_o[k].vs2   = ext_q[2*k+1];
         op_rsp_o[k].valid = out_vld_q.op[k];
      end
      store_data_o  = ext_q[st_port_q];
      store_valid_o = out_vld_q.st;
   end

   // SEW steers the trim three cycles later
   for (genvar k = 0; k < `LANE_W_PORTS; k++) begin : g_chk
      a_sew_known : assert property (
         @(posedge clk_i) disable iff (!rstn_i)
         op_req_i[k].valid |-> !$isunknown(op_req_i[k].sew)
      );
   end

endmodule

`default_nettype wire

// ==== design/lane_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lane_settings.svh"

module lane_regfile (
   input  wire logic                                  clk_i,
   input  wire logic                                  rstn_i,
   input  wire lane_pkg::vrf_wr_t [`LANE_W_PORTS-1:0] wr_i,
   input  wire lane_pkg::vaddr_t  [`LANE_R_PORTS-1:0] raddr_i,
   output lane_pkg::word_t        [`LANE_R_PORTS-1:0] rdata_o
);

   import lane_pkg::*;

   word_t                                     mem [`LANE_DEPTH];
   vaddr_t [`LANE_R_PORTS-1:0]                addr_q;
   word_t  [`LANE_RAM_LAT-1:0][`LANE_R_PORTS-1:0] rd_q;

   ////////////////////////////////////////////////////////////////////////////
   // Write ports

   // Byte granular writes, port 1 is applied last so it wins on a collision
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int a = 0; a < `LANE_DEPTH; a++) begin
            mem[a] <= '0;
         end
      end else begin
         for (int p = 0; p < `LANE_W_PORTS; p++) begin
            for (int b = 0; b < `LANE_WORD/8; b++) begin
               if (wr_i[p].be[b]) begin
                  mem[wr_i[p].addr][b*8 +: 8] <= wr_i[p].data[b*8 +: 8];
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read ports

   // Address register, array read, then output stages
   always_ff @(posedge clk_i) begin
      addr_q <= raddr_i;
      for (int p = 0; p < `LANE_R_PORTS; p++) begin
         rd_q[0][p] <= mem[addr_q[p]];
      end
      for (int s = 1; s < `LANE_RAM_LAT; s++) begin
         rd_q[s] <= rd_q[s-1];
      end
   end

   assign rdata_o = rd_q[`LANE_RAM_LAT-1];

   // Enables come from the write pipeline, an X here would corrupt whole words
   for (genvar p = 0; p < `LANE_W_PORTS; p++) begin : g_chk
      a_be_known : assert property (
         @(posedge clk_i) disable iff (!rstn_i)
         !$isunknown(wr_i[p].be)
      );
   end

endmodule

`default_nettype wire

// ==== design/lane_settings.svh ====
`ifndef LANE_SETTINGS_SVH
`define LANE_SETTINGS_SVH

// Write ports, one per ALU slot
`define LANE_W_PORTS 2

// Each slot reads vs1 and vs2
`define LANE_R_PORTS (2 * `LANE_W_PORTS)

// VRF geometry
`define LANE_DEPTH 32
`define LANE_WORD 32

// Cycles from read address capture to data on the read ports
`define LANE_RAM_LAT 2

// Register stages between a write request and the VRF write
`define LANE_WR_DELAY 2

`endif

// ==== design/lane_write_path.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lane_settings.svh"

module lane_write_path (
   input  wire logic                                  clk_i,
   input  wire logic                                  rstn_i,
   input  wire lane_pkg::wr_req_t [`LANE_W_PORTS-1:0] wr_req_i,
   input  wire lane_pkg::word_t                       load_data_i,
   output lane_pkg::vrf_wr_t      [`LANE_W_PORTS-1:0] vrf_wr_o
);

   import lane_pkg::*;

   localparam int unsigned LAST = `LANE_WR_DELAY - 1;

   // Payload of one write as it travels down the pipe
   typedef struct packed {
      vaddr_t                  addr;
      word_t                   data;
      logic [`LANE_WORD/8-1:0] be;
      logic                    mask_en;
      logic                    mask;
   } wr_stage_t;

   wr_stage_t [`LANE_W_PORTS-1:0]                     stg_d;
   wr_stage_t [`LANE_WR_DELAY-1:0][`LANE_W_PORTS-1:0] stg_q;
   logic      [`LANE_WR_DELAY-1:0][`LANE_W_PORTS-1:0] vld_q;
   logic      [`LANE_W_PORTS-1:0]                     keep;

   // Data select, ALU result or the shared load word
   always_comb begin
      for (int p = 0; p < `LANE_W_PORTS; p++) begin
         stg_d[p].addr    = wr_req_i[p].addr;
         stg_d[p].data    = wr_req_i[p].src ? load_data_i : wr_req_i[p].alu_data;
         stg_d[p].be      = wr_req_i[p].be;
         stg_d[p].mask_en = wr_req_i[p].mask_en;
         stg_d[p].mask    = wr_req_i[p].mask;
      end
   end

   always_ff @(posedge clk_i) begin
      stg_q[0] <= stg_d;
      for (int s = 1; s < `LANE_WR_DELAY; s++) begin
         stg_q[s] <= stg_q[s-1];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         vld_q <= '0;
      end else begin
         for (int p = 0; p < `LANE_W_PORTS; p++) begin
            vld_q[0][p] <= wr_req_i[p].valid;
         end
         for (int s = 1; s < `LANE_WR_DELAY; s++) begin
            vld_q[s] <= vld_q[s-1];
         end
      end
   end

   // Final stage, masked off or idle writes lose all byte enables
   always_comb begin
      for (int p = 0; p < `LANE_W_PORTS; p++) begin
         keep[p] = vld_q[LAST][p] & (~stg_q[LAST][p].mask_en | stg_q[LAST][p].mask);
         vrf_wr_o[p].addr = stg_q[LAST][p].addr;
         vrf_wr_o[p].data = stg_q[LAST][p].data;
         vrf_wr_o[p].be   = stg_q[LAST][p].be & {(`LANE_WORD/8){keep[p]}};
      end
   end

   // An idle request never reaches the array
   for (genvar p = 0; p < `LANE_W_PORTS; p++) begin : g_chk
      a_idle_no_write : assert property (
         @(posedge clk_i) disable iff (!rstn_i)
         !wr_req_i[p].valid |-> ##`LANE_WR_DELAY (vrf_wr_o[p].be == '0)
      );
   end

endmodule

`default_nettype wire

// ==== design/vector_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lane_settings.svh"

module vector_lane (
   input  wire logic                                  clk_i,
   input  wire logic                                  rstn_i,
   input  wire lane_pkg::wr_req_t [`LANE_W_PORTS-1:0] wr_req_i,
   input  wire lane_pkg::word_t                       load_data_i,
   input  wire lane_pkg::op_req_t [`LANE_W_PORTS-1:0] op_req_i,
   input  wire lane_pkg::st_req_t                     st_req_i,
   output lane_pkg::op_rsp_t      [`LANE_W_PORTS-1:0] op_rsp_o,
   output lane_pkg::word_t                            store_data_o,
   output logic                                       store_valid_o
);

   import lane_pkg::*;

   // Resolved writes into the VRF
   vrf_wr_t [`LANE_W_PORTS-1:0] vrf_wr;

   // Read port addresses and raw data
   vaddr_t  [`LANE_R_PORTS-1:0] raddr;
   word_t   [`LANE_R_PORTS-1:0] rdata;

   ////////////////////////////////////////////////////////////////////////////
   // Write pipeline in front of the VRF

   lane_write_path u_write_path (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .wr_req_i    (wr_req_i),
      .load_data_i (load_data_i),
      .vrf_wr_o    (vrf_wr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Register file

   lane_regfile u_regfile (
      .clk_i   (clk_i),
      .rstn_i  (rstn_i),
      .wr_i    (vrf_wr),
      .raddr_i (raddr),
      .rdata_o (rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Operand and store delivery

   lane_read_path u_read_path (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .op_req_i      (op_req_i),
      .st_req_i      (st_req_i),
      .rdata_i       (rdata),
      .raddr_o       (raddr),
      .op_rsp_o      (op_rsp_o),
      .store_data_o  (store_data_o),
      .store_valid_o (store_valid_o)
   );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/lane_pkg.sv
design/lane_regfile.sv
design/lane_write_path.sv
design/lane_read_path.sv
design/vector_lane.sv
verif/vector_lane_tb.sv

// ==== verif/vector_lane_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lane_settings.svh"

module vector_lane_tb;

   import lane_pkg::*;

   localparam int LAT       = 3;
   localparam int WR_LAT    = 2;
   localparam int ROUNDS    = 9;
   localparam int PHASE_LEN = 24;
   localparam int WAIT_MAX  = 50;

   // Expected outputs for one issued cycle
   typedef struct packed {
      op_rsp_t [`LANE_W_PORTS-1:0] rsp;
      word_t                       st_data;
      logic                        st_valid;
   } expect_t;

   logic                        clk_i = 1'b0;
   logic                        rstn_i;
   wr_req_t [`LANE_W_PORTS-1:0] wr_req_i;
   word_t                       load_data_i;
   op_req_t [`LANE_W_PORTS-1:0] op_req_i;
   st_req_t                     st_req_i;
   op_rsp_t [`LANE_W_PORTS-1:0] op_rsp_o;
   word_t                       store_data_o;
   logic                        store_valid_o;

   logic [31:0]                 lfsr_state;
   word_t                       model_mem [`LANE_DEPTH];
   vrf_wr_t [`LANE_W_PORTS-1:0] pend [WR_LAT];
   expect_t                     exp_q [$];
   int                          err_cnt;
   int                          timeout_cnt;
   int                          check_cnt;

   vector_lane uut (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .wr_req_i      (wr_req_i),
      .load_data_i   (load_data_i),
      .op_req_i      (op_req_i),
      .st_req_i      (st_req_i),
      .op_rsp_o      (op_rsp_o),
      .store_data_o  (store_data_o),
      .store_valid_o (store_valid_o)
   );

   always #5 clk_i = ~clk_i;

   // Two rising edges under reset and release on a falling edge
   initial begin
      rstn_i = 1'b0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rstn_i = 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random source with taps 32 22 2 1

   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reference model

   // Zero extended byte or halfword or else the whole word
   function automatic word_t expected_trim(word_t w, sew_t sew, bsel_t bsel);
      case (sew)
         SEW_8:   return (w >> (8 * bsel)) & 32'h0000_00ff;
         SEW_16:  return (w >> (16 * bsel[1])) & 32'h0000_ffff;
         default: return w;
      endcase
   endfunction

   function automatic vrf_wr_t resolve_write(wr_req_t r, word_t ld);
      vrf_wr_t w;
      w.addr = r.addr;
      w.data = r.src ? ld : r.alu_data;
      // Masked off lanes keep their old bytes
      w.be   = (r.valid && !(r.mask_en && !r.mask)) ? r.be : '0;
      return w;
   endfunction

   // Port 1 goes last and wins on the same address
   task automatic apply_writes(vrf_wr_t [`LANE_W_PORTS-1:0] w);
      for (int p = 0; p < `LANE_W_PORTS; p++) begin
         for (int b = 0; b < `LANE_WORD/8; b++) begin
            if (w[p].be[b]) begin
               model_mem[w[p].addr][8*b +: 8] = w[p].data[8*b +: 8];
            end
         end
      end
   endtask

   function automatic logic pending_valid();
      foreach (exp_q[i]) begin
         if (exp_q[i].st_valid || exp_q[i].rsp[0].valid || exp_q[i].rsp[1].valid) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic check_rsp(int slot, op_rsp_t got, op_rsp_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Fail %0t: slot %0d got vs1 %h vs2 %h valid %b, expected vs1 %h vs2 %h valid %b",
                  $time, slot, got.vs1, got.vs2, got.valid, exp.vs1, exp.vs2, exp.valid);
      end
   endtask

   task automatic check_store(word_t got_data, logic got_valid, word_t exp_data, logic exp_valid);
      check_cnt++;
      if (got_valid !== exp_valid || (exp_valid && got_data !== exp_data)) begin
         err_cnt++;
         $display("Fail %0t: store got %h valid %b, expected %h valid %b",
                  $time, got_data, got_valid, exp_data, exp_valid);
      end
   endtask

   task automatic check_valid(string what, logic got, logic exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_outputs();
      expect_t e;
      if (exp_q.size() > LAT) begin
         e = exp_q.pop_front();
         for (int k = 0; k < `LANE_W_PORTS; k++) begin
            if (e.rsp[k].valid) begin
               check_rsp(k, op_rsp_o[k], e.rsp[k]);
            end else begin
               check_valid($sformatf("slot %0d valid", k), op_rsp_o[k].valid, 1'b0);
            end
         end
         check_store(store_data_o, store_valid_o, e.st_data, e.st_valid);
      end else begin
         // Pipeline still holds its reset state
         for (int k = 0; k < `LANE_W_PORTS; k++) begin
            check_valid($sformatf("slot %0d valid", k), op_rsp_o[k].valid, 1'b0);
         end
         check_valid("store valid", store_valid_o, 1'b0);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus

   // One clock step that checks last results and then drives the next request
   task automatic run_cycle(wr_req_t [`LANE_W_PORTS-1:0] w, word_t ld,
                            op_req_t [`LANE_W_PORTS-1:0] o, st_req_t s);
      expect_t e;
      word_t   port_val [`LANE_R_PORTS];
      @(negedge clk_i);
      check_outputs();
      apply_writes(pend[WR_LAT-1]);
      for (int i = WR_LAT - 1; i > 0; i--) begin
         pend[i] = pend[i-1];
      end
      for (int p = 0; p < `LANE_W_PORTS; p++) begin
         pend[0][p] = resolve_write(w[p], ld);
      end
      wr_req_i    = w;
      load_data_i = ld;
      op_req_i    = o;
      st_req_i    = s;
      for (int k = 0; k < `LANE_W_PORTS; k++) begin
         port_val[2*k]   = expected_trim(model_mem[o[k].vs1_addr], o[k].sew, o[k].vs1_bsel);
         port_val[2*k+1] = expected_trim(model_mem[o[k].vs2_addr], o[k].sew, o[k].vs2_bsel);
         e.rsp[k].vs1    = port_val[2*k];
         e.rsp[k].vs2    = port_val[2*k+1];
         e.rsp[k].valid  = o[k].valid;
      end
      e.st_data  = port_val[s.port];
      e.st_valid = s.valid;
      exp_q.push_back(e);
   endtask

   task automatic idle_cycles(int n);
      for (int i = 0; i < n; i++) begin
         run_cycle('0, '0, '0, '0);
      end
   endtask

   // Mode 0 gives full ALU words and mode 1 partial load words while higher modes mix in masks
   function automatic wr_req_t gen_write(int mode);
      wr_req_t r;
      r.addr     = vaddr_t'(take_bits($bits(vaddr_t)));
      r.alu_data = take_bits(32);
      r.valid    = (take_bits(3) != 0);
      r.src      = (mode == 1) ? 1'b1 : ((mode == 0) ? 1'b0 : 1'(take_bits(1)));
      r.be       = (mode == 0) ? 4'hf : 4'(take_bits(4));
      r.mask_en  = (mode >= 2) ? 1'(take_bits(1)) : 1'b0;
      r.mask     = (mode >= 2) ? 1'(take_bits(1)) : 1'b0;
      return r;
   endfunction

   function automatic op_req_t gen_read(int mode);
      op_req_t r;
      r.vs1_addr = vaddr_t'(take_bits($bits(vaddr_t)));
      r.vs2_addr = vaddr_t'(take_bits($bits(vaddr_t)));
      r.vs1_bsel = bsel_t'(take_bits(2));
      r.vs2_bsel = bsel_t'(take_bits(2));
      r.sew      = (mode == 0) ? SEW_32 : sew_t'(2'(take_bits(2)));
      r.valid    = (take_bits(3) != 0);
      return r;
   endfunction

   task automatic write_phase(int mode);
      wr_req_t [`LANE_W_PORTS-1:0] w;
      for (int i = 0; i < PHASE_LEN; i++) begin
         for (int p = 0; p < `LANE_W_PORTS; p++) begin
            w[p] = gen_write(mode);
         end
         // Force collisions now and then
         if (mode == 1 && take_bits(1) == 1) begin
            w[1].addr = w[0].addr;
         end
         run_cycle(w, take_bits(32), '0, '0);
      end
   endtask

   task automatic read_phase(int mode);
      op_req_t [`LANE_W_PORTS-1:0] o;
      st_req_t                     s;
      for (int i = 0; i < PHASE_LEN; i++) begin
         for (int k = 0; k < `LANE_W_PORTS; k++) begin
            o[k] = gen_read(mode);
         end
         s.port  = rport_t'(take_bits(2));
         s.valid = 1'(take_bits(1));
         run_cycle('0, '0, o, s);
      end
   endtask

   // Reset moves on falling edges so it is looked at on rising ones
   task automatic wait_reset_release();
      int n;
      n = 0;
      @(posedge clk_i);
      while (rstn_i !== 1'b1 && n < WAIT_MAX) begin
         @(negedge clk_i);
         check_valid("slot 0 valid in reset", op_rsp_o[0].valid, 1'b0);
         check_valid("slot 1 valid in reset", op_rsp_o[1].valid, 1'b0);
         check_valid("store valid in reset", store_valid_o, 1'b0);
         @(posedge clk_i);
         n++;
      end
      if (rstn_i !== 1'b1) begin
         timeout_cnt++;
         $display("Timeout: reset was not released within %0d cycles", WAIT_MAX);
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (pending_valid() && n < WAIT_MAX) begin
         idle_cycles(1);
         n++;
      end
      if (pending_valid()) begin
         timeout_cnt++;
         $display("Timeout: responses still pending after %0d idle cycles", WAIT_MAX);
      end
   endtask

   initial begin
      wr_req_i    = '0;
      load_data_i = '0;
      op_req_i    = '0;
      st_req_i    = '0;
      lfsr_state  = 32'h1e2f;
      err_cnt     = 0;
      timeout_cnt = 0;
      check_cnt   = 0;
      for (int a = 0; a < `LANE_DEPTH; a++) begin
         model_mem[a] = '0;
      end
      for (int i = 0; i < WR_LAT; i++) begin
         pend[i] = '0;
      end
      wait_reset_release();
      // Cleared VRF first
      read_phase(3);
      idle_cycles(LAT);
      for (int r = 0; r < ROUNDS; r++) begin
         write_phase(r % 3);
         idle_cycles(LAT);
         read_phase(r % 3);
         idle_cycles(2);
      end
      drain();
      $display("Checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
